// ==== list.f ====
design/vng_pkg.sv
design/vng_window_feeder.sv
design/vng_diag_lane.sv
design/vng_gradient_collector.sv
design/vng_diag_top.sv
tests/vng_diag_tb.sv

// ==== tests/vng_diag_tb.sv ====
`timescale 1ns/1ps

module vng_diag_tb
    import vng_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int ROWS       = 6;
    localparam int FRAME_PX   = ROWS * LINE_W;
    // three full lines plus a few pixels, then sof cuts in
    localparam int PART_PX    = 3 * LINE_W + 5;
    localparam int MAX_GAP    = 3;
    localparam int SETTLE     = 8;
    localparam int IDLE_TEST  = 20;
    localparam int NUM_FRAMES = 5;
    localparam int FULL_WIN   = (ROWS - 2) * (LINE_W - 2);
    localparam int PART_WIN   = (LINE_W - 2) + 3;

    localparam int TOTAL_PX     = NUM_FRAMES * FRAME_PX + PART_PX;
    localparam int IDLE_CYCLES  = 2 + IDLE_TEST + FRAME_PX * MAX_GAP + 10 * (SETTLE + 4);
    localparam int LIMIT_CYCLES = TOTAL_PX + IDLE_CYCLES + 100;

    localparam int KIND_RANDOM  = 0;
    localparam int KIND_FLAT    = 1;
    localparam int KIND_EXTREME = 2;

    logic         clk;
    logic         rst_n;
    logic         sof;
    logic         px_valid;
    pixel_t       px;
    logic         out_valid;
    diag_result_t result;

    // copy of the frame being driven, used by the reference model
    pixel_t       frame [ROWS][LINE_W];

    diag_result_t exp_q [$];
    int           exp_cyc_q [$];

    int           cycle   = 0;
    int           errors  = 0;
    int           results = 0;
    string        cur_test = "none";
    logic         flat_mode = 1'b0;
    pixel_t       flat_val  = '0;

    vng_diag_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .sof       (sof),
        .px_valid  (px_valid),
        .px        (px),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic int absdiff(input int a, input int b);
        return (a > b) ? a - b : b - a;
    endfunction

    // window ends at (row, col), centre at (row-1, col-1)
    function automatic diag_result_t vng_expect(input int row, input int col);
        int                 w [3][3];
        int                 corner [NUM_DIR];
        int                 grad [NUM_DIR];
        int                 gmin;
        int                 gmax;
        int                 thr;
        int                 sum;
        int                 cnt;
        logic [NUM_DIR-1:0] mask;
        diag_result_t       res;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                w[r][c] = frame[row - 2 + r][col - 2 + c];
            end
        end
        corner[DIR_NE] = w[0][2];
        corner[DIR_SE] = w[2][2];
        corner[DIR_SW] = w[2][0];
        corner[DIR_NW] = w[0][0];
        grad[DIR_NE] = absdiff(w[0][2], w[1][1]) + absdiff(w[0][1], w[1][2]);
        grad[DIR_SE] = absdiff(w[2][2], w[1][1]) + absdiff(w[1][2], w[2][1]);
        grad[DIR_SW] = absdiff(w[2][0], w[1][1]) + absdiff(w[2][1], w[1][0]);
        grad[DIR_NW] = absdiff(w[0][0], w[1][1]) + absdiff(w[1][0], w[0][1]);
        gmin = grad[0];
        gmax = grad[0];
        for (int k = 1; k < NUM_DIR; k++) begin
            if (grad[k] < gmin) gmin = grad[k];
            if (grad[k] > gmax) gmax = grad[k];
        end
        thr  = gmin + (gmax - gmin) / 2;
        mask = '0;
        sum  = 0;
        cnt  = 0;
        for (int k = 0; k < NUM_DIR; k++) begin
            if (grad[k] <= thr) begin
                mask[k] = 1'b1;
                sum     = sum + corner[k];
                cnt     = cnt + 1;
            end
        end
        res.mask       = mask;
        res.corner_sum = sum[SUM_W-1:0];
        res.count      = cnt[2:0];
        return res;
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // sampled on the next edge, result due three edges after that
    task automatic push_pixel(input pixel_t value, input logic start,
                              input int row, input int col);
        frame[row][col] = value;
        sof      = start;
        px_valid = 1'b1;
        px       = value;
        if (row >= 2 && col >= 2) begin
            exp_q.push_back(vng_expect(row, col));
            exp_cyc_q.push_back(cycle + 4);
        end
        @(posedge clk);
        #2;
        sof      = 1'b0;
        px_valid = 1'b0;
    endtask

    task automatic run_frame(input int kind, input int num_px, input int max_gap);
        pixel_t value;
        for (int i = 0; i < num_px; i++) begin
            case (kind)
                KIND_FLAT:    value = flat_val;
                KIND_EXTREME: value = ($urandom % 2) ? 8'hff : 8'h00;
                default:      value = pixel_t'($urandom % 256);
            endcase
            push_pixel(value, i == 0, i / LINE_W, i % LINE_W);
            if (max_gap > 0) begin
                idle($urandom % (max_gap + 1));
            end
        end
    endtask

    task automatic drain_and_count(input int start_results, input int exp_windows);
        int waited;
        waited = 0;
        // last result is due four cycles after the last pixel
        while (exp_q.size() != 0 && waited < SETTLE) begin
            @(posedge clk);
            #2;
            waited++;
        end
        idle(SETTLE);
        check({cur_test, " window count"}, exp_windows, results - start_results);
    endtask

    always @(negedge clk) begin : compare
        diag_result_t exp_res;
        int           exp_cyc;
        if (out_valid === 1'b1) begin
            results++;
            if (exp_q.size() == 0) begin
                $display("ERROR: out_valid in %s with no result pending", cur_test);
                errors++;
            end else begin
                exp_res = exp_q.pop_front();
                exp_cyc = exp_cyc_q.pop_front();
                check({cur_test, " result"}, exp_res, result);
                check({cur_test, " latency"}, exp_cyc, cycle);
                if (flat_mode) begin
                    check({cur_test, " flat mask"}, 4'hf, result.mask);
                    check({cur_test, " flat count"}, 3'd4, result.count);
                    check({cur_test, " flat sum"}, 4 * flat_val, result.corner_sum);
                end
            end
        end
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("ERROR: timeout, run exceeded %0d cycles in %s", LIMIT_CYCLES, cur_test);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int seed_val;
        int start;
        rst_n    = 1'b0;
        sof      = 1'b0;
        px_valid = 1'b0;
        px       = '0;
        seed_val = $urandom(76);
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        cur_test = "idle_after_reset";
        repeat (IDLE_TEST) begin
            @(negedge clk);
            check({cur_test, " out_valid"}, 1'b0, out_valid);
        end
        @(posedge clk);
        #2;
        check({cur_test, " window count"}, 0, results);

        cur_test = "random_continuous";
        start = results;
        run_frame(KIND_RANDOM, FRAME_PX, 0);
        drain_and_count(start, FULL_WIN);

        cur_test  = "flat_frame";
        flat_val  = pixel_t'($urandom % 256);
        flat_mode = 1'b1;
        start = results;
        run_frame(KIND_FLAT, FRAME_PX, 0);
        drain_and_count(start, FULL_WIN);
        flat_mode = 1'b0;

        cur_test = "random_gaps";
        start = results;
        run_frame(KIND_RANDOM, FRAME_PX, MAX_GAP);
        drain_and_count(start, FULL_WIN);

        // new frame starts before the old one is complete
        cur_test = "sof_restart";
        start = results;
        run_frame(KIND_RANDOM, PART_PX, 0);
        run_frame(KIND_RANDOM, FRAME_PX, 0);
        drain_and_count(start, PART_WIN + FULL_WIN);

        cur_test = "extreme_values";
        start = results;
        run_frame(KIND_EXTREME, FRAME_PX, 0);
        drain_and_count(start, FULL_WIN);

        if (exp_q.size() != 0) begin
            $display("ERROR: %0d expected results never appeared", exp_q.size());
            errors++;
        end
        $display("errors=%0d results=%0d", errors, results);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== design/vng_diag_top.sv ====
`timescale 1ns/1ps

module vng_diag_top
    import vng_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         sof,
    input  logic         px_valid,
    input  pixel_t       px,
    output logic         out_valid,
    output diag_result_t result
);

    logic               win_valid;
    lane_in_t           lane_in  [NUM_DIR];
    lane_out_t          lane_out [NUM_DIR];
    // lanes run in lockstep, lane 0 carries the valid downstream
    logic [NUM_DIR-1:0] lane_valid;

    vng_window_feeder feeder0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .sof       (sof),
        .px_valid  (px_valid),
        .px        (px),
        .win_valid (win_valid),
        .lanes     (lane_in)
    );

    for (genvar k = 0; k < NUM_DIR; k++) begin : g_lane
        vng_diag_lane lane0 (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (win_valid),
            .in        (lane_in[k]),
            .out_valid (lane_valid[k]),
            .out       (lane_out[k])
        );
    end

    vng_gradient_collector collector0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (lane_valid[DIR_NE]),
        .lanes     (lane_out),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

// ==== design/vng_gradient_collector.sv ====
`timescale 1ns/1ps

module vng_gradient_collector
    import vng_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    input  lane_out_t    lanes [NUM_DIR],
    output logic         out_valid,
    output diag_result_t result
);

    logic [GRAD_W-1:0] grad_min;
    logic [GRAD_W-1:0] grad_max;

    // stage 1 registers
    logic              s1_valid;
    logic [GRAD_W-1:0] s1_min;
    logic [GRAD_W-1:0] s1_max;
    logic [GRAD_W-1:0] s1_grad [NUM_DIR];
    pixel_t            s1_corner [NUM_DIR];

    // stage 2 inputs
    logic [GRAD_W-1:0]  thresh;
    logic [NUM_DIR-1:0] sel_mask;
    logic [SUM_W-1:0]   sel_sum;
    logic [2:0]         sel_count;

    // min/max over the four lanes
    always_comb begin
        grad_min = lanes[0].grad;
        grad_max = lanes[0].grad;
        for (int k = 1; k < NUM_DIR; k++) begin
            if (lanes[k].grad < grad_min) begin
                grad_min = lanes[k].grad;
            end
            if (lanes[k].grad > grad_max) begin
                grad_max = lanes[k].grad;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_min <= grad_min;
        s1_max <= grad_max;
        for (int k = 0; k < NUM_DIR; k++) begin
            s1_grad[k]   <= lanes[k].grad;
            s1_corner[k] <= lanes[k].corner;
        end
    end

    // threshold sits halfway between min and max, never above max
    always_comb begin
        thresh    = s1_min + ((s1_max - s1_min) >> 1);
        sel_mask  = '0;
        sel_sum   = '0;
        sel_count = '0;
        for (int k = 0; k < NUM_DIR; k++) begin
            if (s1_grad[k] <= thresh) begin
                sel_mask[k] = 1'b1;
                sel_sum     = sel_sum + SUM_W'(s1_corner[k]);
                sel_count   = sel_count + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        result.mask       <= sel_mask;
        result.corner_sum <= sel_sum;
        result.count      <= sel_count;
    end

endmodule

// ==== design/vng_diag_lane.sv ====
`timescale 1ns/1ps

module vng_diag_lane
    import vng_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  lane_in_t  in,
    output logic      out_valid,
    output lane_out_t out
);

    pixel_t            diff_corner;
    pixel_t            diff_edge;
    logic [GRAD_W-1:0] grad;

    always_comb begin
        diff_corner = (in.corner >= in.center) ? in.corner - in.center
                                               : in.center - in.corner;
        diff_edge   = (in.edge_a >= in.edge_b) ? in.edge_a - in.edge_b
                                               : in.edge_b - in.edge_a;
        // two 8 bit magnitudes, carry lands in the top bit
        grad        = {1'b0, diff_corner} + {1'b0, diff_edge};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        out.grad   <= grad;
        out.corner <= in.corner;
    end

endmodule

// ==== design/vng_window_feeder.sv ====
`timescale 1ns/1ps

module vng_window_feeder
    import vng_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     sof,
    input  logic     px_valid,
    input  pixel_t   px,
    output logic     win_valid,
    output lane_in_t lanes [NUM_DIR]
);

    // line0 holds the row two up, line1 the row just above
    pixel_t line0 [LINE_W];
    pixel_t line1 [LINE_W];

    // win[r][c], r = 0 is the oldest row, c = 0 the leftmost column
    pixel_t win [3][3];

    logic [COL_W-1:0] col_cnt;
    logic [1:0]       row_cnt;

    logic [COL_W-1:0] cur_col;
    logic [1:0]       cur_row;
    logic             line_end;
    logic             interior;

    // sof pixel is always (0, 0) of the new frame
    always_comb begin
        cur_col  = sof ? '0 : col_cnt;
        cur_row  = sof ? '0 : row_cnt;
        line_end = (cur_col == COL_W'(LINE_W - 1));
        interior = (cur_row == 2'd2) && (cur_col >= COL_W'(2));
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (px_valid) begin
            if (line_end) begin
                col_cnt <= '0;
                // row count only needs to reach 2
                row_cnt <= (cur_row == 2'd2) ? cur_row : cur_row + 2'd1;
            end else begin
                col_cnt <= cur_col + COL_W'(1);
                row_cnt <= cur_row;
            end
        end else if (sof) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= px_valid && interior;
        end
    end

    // line shift registers, one step per accepted pixel
    always_ff @(posedge clk) begin
        if (px_valid) begin
            line1[0] <= px;
            line0[0] <= line1[LINE_W-1];
            for (int i = 1; i < LINE_W; i++) begin
                line1[i] <= line1[i-1];
                line0[i] <= line0[i-1];
            end
        end
    end

    // window takes in one new column on the right
    always_ff @(posedge clk) begin
        if (px_valid) begin
            for (int r = 0; r < 3; r++) begin
                win[r][0] <= win[r][1];
                win[r][1] <= win[r][2];
            end
            win[0][2] <= line0[LINE_W-1];
            win[1][2] <= line1[LINE_W-1];
            win[2][2] <= px;
        end
    end

    // corner, centre and edge pair for each direction
    always_comb begin
        lanes[DIR_NE].corner = win[0][2];
        lanes[DIR_NE].center = win[1][1];
        lanes[DIR_NE].edge_a = win[0][1];
        lanes[DIR_NE].edge_b = win[1][2];

        lanes[DIR_SE].corner = win[2][2];
        lanes[DIR_SE].center = win[1][1];
        lanes[DIR_SE].edge_a = win[1][2];
        lanes[DIR_SE].edge_b = win[2][1];

        lanes[DIR_SW].corner = win[2][0];
        lanes[DIR_SW].center = win[1][1];
        lanes[DIR_SW].edge_a = win[2][1];
        lanes[DIR_SW].edge_b = win[1][0];

        lanes[DIR_NW].corner = win[0][0];
        lanes[DIR_NW].center = win[1][1];
        lanes[DIR_NW].edge_a = win[1][0];
        lanes[DIR_NW].edge_b = win[0][1];
    end

endmodule

// ==== design/vng_pkg.sv ====
package vng_pkg;

    // pixel and line geometry
    localparam int DATA_W  = 8;
    localparam int LINE_W  = 16;
    localparam int COL_W   = $clog2(LINE_W);

    localparam int NUM_DIR = 4;

    // gradient is the sum of two absolute differences
    localparam int GRAD_W  = DATA_W + 1;
    // up to four corner pixels added together
    localparam int SUM_W   = DATA_W + 2;

    typedef logic [DATA_W-1:0] pixel_t;

    // lane index and mask bit index
    typedef enum logic [1:0] {
        DIR_NE = 2'd0,
        DIR_SE = 2'd1,
        DIR_SW = 2'd2,
        DIR_NW = 2'd3
    } dir_e;

    typedef struct packed {
        pixel_t corner;
        pixel_t center;
        pixel_t edge_a;
        pixel_t edge_b;
    } lane_in_t;

    typedef struct packed {
        logic [GRAD_W-1:0] grad;
        pixel_t            corner;
    } lane_out_t;

    typedef struct packed {
        logic [NUM_DIR-1:0] mask;
        logic [SUM_W-1:0]   corner_sum;
        logic [2:0]         count;
    } diag_result_t;

endpackage
